//--- src.f
+incdir+include
design/dma_pkg.sv
design/dma_regs.sv
design/sample_packer.sv
design/beat_fifo.sv
design/axi_write_master.sv
design/stream_dma.sv
testbench/axi_mem_model.sv
testbench/stream_dma_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the write DMA testbench with Verilator, run it and scan the log for failure
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    --top-module stream_dma_tb \
    -f src.f \
    --Mdir obj_dir \
    -o stream_dma_sim

./obj_dir/stream_dma_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without a failure"

//--- testbench/stream_dma_tb.sv
// Testbench for the stream write DMA with an AXI responder, protocol assertions and data checks
`timescale 1ns/1ps
`include "dma_cfg.svh"

module stream_dma_tb
    import dma_pkg::*;
();

    localparam int NUM_TESTS = 9;
    localparam int NUM_SAMPLES = 105;
    localparam int TIMEOUT_CYCLES = 20 * NUM_SAMPLES + 200 * NUM_TESTS;

    logic axi_out;
    logic rst_n;
    logic [`DMA_REG_ADDR_W-1:0] reg_addr;
    logic [`DMA_REG_DATA_W-1:0] reg_wdata;
    logic reg_valid;
    logic reg_ready;
    sample_t in_data;
    tag_t in_tag;
    logic in_last;
    logic in_valid;
    logic in_ready;
    addr_t awaddr;
    logic [7:0] awlen;
    logic [2:0] awsize;
    logic awvalid;
    logic awready;
    beat_t wdata;
    strb_t wstrb;
    logic wlast;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    logic dma_done;
    logic dma_error;
    addr_t err_addr;
    logic err_en;

    string test_name;
    int errors;
    int errors_at_start;
    int tests_run;
    int tests_ok;
    int done_count;
    int aw_pending;
    logic xfer_active;
    int unsigned cycle_count;

    stream_dma i_dut (
        .axi_out   (axi_out),
        .rst_n     (rst_n),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_valid (reg_valid),
        .reg_ready (reg_ready),
        .in_data   (in_data),
        .in_tag    (in_tag),
        .in_last   (in_last),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .awaddr    (awaddr),
        .awlen     (awlen),
        .awsize    (awsize),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wlast     (wlast),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .dma_done  (dma_done),
        .dma_error (dma_error)
    );

    axi_mem_model i_mem (
        .axi_out  (axi_out),
        .rst_n    (rst_n),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .err_addr (err_addr),
        .err_en   (err_en)
    );

    initial begin
        axi_out = 1'b0;
        forever #5 axi_out = ~axi_out;
    end

    // Writes sent but not yet answered, and the span from a start write to its done pulse
    always @(posedge axi_out or negedge rst_n) begin
        if (!rst_n) begin
            aw_pending <= 0;
            done_count <= 0;
            xfer_active <= 1'b0;
        end else begin
            aw_pending <= aw_pending + int'(awvalid && awready) - int'(bvalid && bready);
            if (dma_done) begin
                done_count <= done_count + 1;
            end
            if (reg_valid && reg_ready && reg_addr == `DMA_REG_CTRL && reg_wdata[0]) begin
                xfer_active <= 1'b1;
            end else if (dma_done) begin
                xfer_active <= 1'b0;
            end
        end
    end

    task automatic report_violation(string msg);
        $display("ERROR in %s: %s", test_name, msg);
        errors++;
    endtask

    reg_port_closed: assert property (@(posedge axi_out) disable iff (!rst_n)
        xfer_active && !dma_done |-> !reg_ready)
        else report_violation("register port was open during a transfer");
    stream_closed: assert property (@(posedge axi_out) disable iff (!rst_n)
        !xfer_active |-> !in_ready)
        else report_violation("stream accepted samples with no transfer running");
    pending_limit: assert property (@(posedge axi_out) disable iff (!rst_n)
        aw_pending <= `DMA_MAX_OUTSTANDING)
        else report_violation("too many writes waiting for a response");
    done_after_resp: assert property (@(posedge axi_out) disable iff (!rst_n)
        dma_done |-> aw_pending == 0 && xfer_active)
        else report_violation("done pulse while responses were still pending");
    done_one_cycle: assert property (@(posedge axi_out) disable iff (!rst_n)
        dma_done |=> !dma_done)
        else report_violation("done pulse lasted more than one cycle");
    single_beat: assert property (@(posedge axi_out) disable iff (!rst_n)
        awvalid |-> awlen == 8'd0 && awsize == 3'd4 && wlast)
        else report_violation("write was not a single 16-byte beat");
    resp_always_taken: assert property (@(posedge axi_out) disable iff (!rst_n)
        bready)
        else report_violation("bready was low");
    aw_held: assert property (@(posedge axi_out) disable iff (!rst_n)
        awvalid && !awready |=> awvalid)
        else report_violation("awvalid dropped before its handshake");
    w_held: assert property (@(posedge axi_out) disable iff (!rst_n)
        wvalid && !wready |=> wvalid)
        else report_violation("wvalid dropped before its handshake");

    task automatic expect_eq(string what, logic [127:0] expected, logic [127:0] actual);
        assert (expected == actual) else begin
            $display("CHECK FAILED %s %s expected %0h actual %0h",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic start_test(string name);
        test_name = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == errors_at_start) begin
            tests_ok++;
            $display("[%s] ok", test_name);
        end else begin
            $display("[%s] %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
        @(negedge axi_out);
        reg_addr = addr;
        reg_wdata = data;
        reg_valid = 1'b1;
        while (!reg_ready) begin
            @(negedge axi_out);
        end
        @(negedge axi_out);
        reg_valid = 1'b0;
    endtask

    // Record layout: tag zero extended to 32 bits above the sample
    function automatic logic [63:0] expected_record(sample_t data_base, int tag_base, int i);
        return {20'h0, tag_t'(tag_base + i), data_base + sample_t'(i)};
    endfunction

    task automatic run_transfer(input addr_t base, input int count, input int last_at,
                                input logic set_count, input logic stray_write,
                                input logic exp_err);
        int n_sent;
        int n_beats;
        int n_logged;
        int log_base;
        int done_base;
        int tag_base;
        sample_t data_base;
        beat_t exp_beat;
        strb_t exp_strb;

        n_sent = (last_at >= 0 && last_at < count) ? last_at + 1 : count;
        n_beats = (n_sent + 1) / 2;
        data_base = {8'hA5, 8'(tests_run), 16'h0};
        tag_base = tests_run * 32;

        reg_write(`DMA_REG_BASE_LO, base[31:0]);
        reg_write(`DMA_REG_BASE_HI, 32'(base[`DMA_ADDR_W-1:32]));
        if (set_count) begin
            reg_write(`DMA_REG_COUNT, 32'(count));
        end
        log_base = i_mem.log_addr.size();
        done_base = done_count;
        reg_write(`DMA_REG_CTRL, 32'h1);

        if (stray_write) begin
            // Offered while busy and withdrawn without a handshake
            reg_addr = `DMA_REG_COUNT;
            reg_wdata = 32'd3;
            reg_valid = 1'b1;
            repeat (5) @(negedge axi_out);
            reg_valid = 1'b0;
        end

        for (int i = 0; i < n_sent; i++) begin
            @(negedge axi_out);
            in_data = data_base + sample_t'(i);
            in_tag = tag_t'(tag_base + i);
            in_last = (i == last_at);
            in_valid = 1'b1;
            while (!in_ready) begin
                @(negedge axi_out);
            end
        end
        @(negedge axi_out);
        in_valid = 1'b0;
        in_last = 1'b0;

        while (done_count == done_base) begin
            @(negedge axi_out);
        end

        n_logged = i_mem.log_addr.size() - log_base;
        expect_eq("write count", n_beats, n_logged);
        for (int k = 0; k < n_beats && k < n_logged; k++) begin
            exp_beat[63:0] = expected_record(data_base, tag_base, 2 * k);
            if (2 * k + 1 < n_sent) begin
                exp_beat[127:64] = expected_record(data_base, tag_base, 2 * k + 1);
                exp_strb = 16'hFFFF;
            end else begin
                // A frame that ends on a lower half leaves the upper record empty
                exp_beat[127:64] = '0;
                exp_strb = 16'h00FF;
            end
            expect_eq($sformatf("awaddr %0d", k), base + addr_t'(16 * k),
                      i_mem.log_addr[log_base + k]);
            expect_eq($sformatf("wdata %0d", k), exp_beat, i_mem.log_data[log_base + k]);
            expect_eq($sformatf("wstrb %0d", k), exp_strb, i_mem.log_strb[log_base + k]);
        end
        expect_eq("dma_error", exp_err, dma_error);
        expect_eq("in_ready after frame", 0, in_ready);

        // A second done pulse would show up within a few cycles
        repeat (8) @(negedge axi_out);
        expect_eq("done pulses", 1, done_count - done_base);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge axi_out);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("test failed");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        reg_valid = 1'b0;
        in_data = '0;
        in_tag = '0;
        in_last = 1'b0;
        in_valid = 1'b0;
        err_addr = '0;
        err_en = 1'b0;
        errors = 0;
        tests_run = 0;
        tests_ok = 0;
        test_name = "none";

        repeat (10) @(posedge axi_out);
        @(negedge axi_out);
        rst_n = 1'b1;

        start_test("reset");
        expect_eq("reg_ready", 1, reg_ready);
        expect_eq("in_ready", 0, in_ready);
        expect_eq("awvalid", 0, awvalid);
        expect_eq("wvalid", 0, wvalid);
        expect_eq("dma_done", 0, dma_done);
        expect_eq("dma_error", 0, dma_error);
        finish_test();

        start_test("layout");
        run_transfer(49'h0_0000_0000_1000, 16, -1, 1'b1, 1'b0, 1'b0);
        finish_test();

        start_test("odd_count");
        run_transfer(49'h0_0000_0002_0000, 7, -1, 1'b1, 1'b0, 1'b0);
        finish_test();

        start_test("early_last");
        run_transfer(49'h0_0000_0003_0000, 100, 5, 1'b1, 1'b0, 1'b0);
        finish_test();

        start_test("backpressure");
        run_transfer(49'h1_ABCD_0000_4000, 40, -1, 1'b1, 1'b0, 1'b0);
        finish_test();

        start_test("reg_blocked");
        run_transfer(49'h0_0000_0005_0000, 10, -1, 1'b1, 1'b1, 1'b0);
        finish_test();

        // Count register is not rewritten, so the earlier value must still hold
        start_test("reg_kept");
        run_transfer(49'h0_0000_0006_0000, 10, -1, 1'b0, 1'b0, 1'b0);
        finish_test();

        start_test("slverr");
        err_addr = 49'h0_0000_0007_0020;
        err_en = 1'b1;
        run_transfer(49'h0_0000_0007_0000, 8, -1, 1'b1, 1'b0, 1'b1);
        err_en = 1'b0;
        finish_test();

        start_test("error_clear");
        run_transfer(49'h0_0000_0008_0000, 8, -1, 1'b1, 1'b0, 1'b0);
        finish_test();

        $display("%0d of %0d tests ok, %0d errors", tests_ok, tests_run, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- testbench/axi_mem_model.sv
// AXI write responder with random channel stalls, delayed responses and a log of every write
`timescale 1ns/1ps
`include "dma_cfg.svh"

module axi_mem_model
    import dma_pkg::*;
(
    input  logic       axi_out,
    input  logic       rst_n,
    input  addr_t      awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  beat_t      wdata,
    input  strb_t      wstrb,
    input  logic       wvalid,
    output logic       wready,
    output logic [1:0] bresp,
    output logic       bvalid,
    input  logic       bready,
    input  addr_t      err_addr,
    input  logic       err_en
);

    logic [31:0] lfsr;
    int unsigned cycle;
    addr_t cur_addr;
    addr_t aw_q[$];
    beat_t wd_q[$];
    strb_t ws_q[$];
    logic [1:0] resp_q[$];
    int unsigned due_q[$];

    // Every write that has both its address and its data, in arrival order
    addr_t log_addr[$];
    beat_t log_data[$];
    strb_t log_strb[$];

    // Fibonacci LFSR with taps 32 22 2 1, stepped once per random bit
    function automatic logic [3:0] random_bits(int n);
        logic [3:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[2:0], lfsr[0]};
        end
        return v;
    endfunction

    always @(posedge axi_out or negedge rst_n) begin
        if (!rst_n) begin
            lfsr = 32'h4543;
            cycle <= 0;
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            bresp <= 2'b00;
            aw_q.delete();
            wd_q.delete();
            ws_q.delete();
            resp_q.delete();
            due_q.delete();
        end else begin
            cycle <= cycle + 1;
            if (awvalid && awready) begin
                aw_q.push_back(awaddr);
            end
            if (wvalid && wready) begin
                wd_q.push_back(wdata);
                ws_q.push_back(wstrb);
            end

            // A write is complete once both its address and its data have arrived
            if (aw_q.size() > 0 && wd_q.size() > 0) begin
                cur_addr = aw_q.pop_front();
                log_addr.push_back(cur_addr);
                log_data.push_back(wd_q.pop_front());
                log_strb.push_back(ws_q.pop_front());
                resp_q.push_back((err_en && cur_addr == err_addr) ? 2'b10 : 2'b00);
                due_q.push_back(cycle + 1 + random_bits(4));
            end

            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if ((!bvalid || bready) && due_q.size() > 0 && due_q[0] <= cycle) begin
                bvalid <= 1'b1;
                bresp <= resp_q.pop_front();
                void'(due_q.pop_front());
            end

            // Each ready is high three cycles out of four on average
            awready <= (random_bits(2) != 4'h0);
            wready <= (random_bits(2) != 4'h0);
        end
    end

endmodule

//--- design/stream_dma.sv
// Stream-to-memory write DMA top level
`timescale 1ns/1ps
`include "dma_cfg.svh"

module stream_dma
    import dma_pkg::*;
(
    input  logic                       axi_out,
    input  logic                       rst_n,
    input  logic [`DMA_REG_ADDR_W-1:0] reg_addr,
    input  logic [`DMA_REG_DATA_W-1:0] reg_wdata,
    input  logic                       reg_valid,
    output logic                       reg_ready,
    input  sample_t                    in_data,
    input  tag_t                       in_tag,
    input  logic                       in_last,
    input  logic                       in_valid,
    output logic                       in_ready,
    output addr_t                      awaddr,
    output logic [7:0]                 awlen,
    output logic [2:0]                 awsize,
    output logic                       awvalid,
    input  logic                       awready,
    output beat_t                      wdata,
    output strb_t                      wstrb,
    output logic                       wlast,
    output logic                       wvalid,
    input  logic                       wready,
    input  logic [1:0]                 bresp,
    input  logic                       bvalid,
    output logic                       bready,
    output logic                       dma_done,
    output logic                       dma_error
);

    addr_t base_addr;
    count_t sample_count;
    logic start;
    logic busy;

    beat_t pk_beat;
    strb_t pk_strb;
    logic pk_last;
    logic pk_valid;
    logic pk_ready;

    beat_t fb_beat;
    strb_t fb_strb;
    logic fb_last;
    logic fb_valid;
    logic fb_ready;

    dma_regs i_regs (
        .axi_out      (axi_out),
        .rst_n        (rst_n),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_valid    (reg_valid),
        .reg_ready    (reg_ready),
        .busy         (busy),
        .base_addr    (base_addr),
        .sample_count (sample_count),
        .start        (start)
    );

    sample_packer i_packer (
        .axi_out      (axi_out),
        .rst_n        (rst_n),
        .start        (start),
        .sample_count (sample_count),
        .in_data      (in_data),
        .in_tag       (in_tag),
        .in_last      (in_last),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .pk_beat      (pk_beat),
        .pk_strb      (pk_strb),
        .pk_last      (pk_last),
        .pk_valid     (pk_valid),
        .pk_ready     (pk_ready)
    );

    beat_fifo #(
        .DEPTH (`DMA_FIFO_DEPTH)
    ) i_fifo (
        .axi_out  (axi_out),
        .rst_n    (rst_n),
        .pk_beat  (pk_beat),
        .pk_strb  (pk_strb),
        .pk_last  (pk_last),
        .pk_valid (pk_valid),
        .pk_ready (pk_ready),
        .fb_beat  (fb_beat),
        .fb_strb  (fb_strb),
        .fb_last  (fb_last),
        .fb_valid (fb_valid),
        .fb_ready (fb_ready)
    );

    axi_write_master i_master (
        .axi_out   (axi_out),
        .rst_n     (rst_n),
        .start     (start),
        .base_addr (base_addr),
        .fb_beat   (fb_beat),
        .fb_strb   (fb_strb),
        .fb_last   (fb_last),
        .fb_valid  (fb_valid),
        .fb_ready  (fb_ready),
        .awaddr    (awaddr),
        .awlen     (awlen),
        .awsize    (awsize),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wlast     (wlast),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .busy      (busy),
        .dma_done  (dma_done),
        .dma_error (dma_error)
    );

endmodule

//--- design/axi_write_master.sv
// Single-beat AXI write issuer with response tracking and completion pulse
`timescale 1ns/1ps
`include "dma_cfg.svh"

module axi_write_master
    import dma_pkg::*;
(
    input  logic       axi_out,
    input  logic       rst_n,
    input  logic       start,
    input  addr_t      base_addr,
    input  beat_t      fb_beat,
    input  strb_t      fb_strb,
    input  logic       fb_last,
    input  logic       fb_valid,
    output logic       fb_ready,
    output addr_t      awaddr,
    output logic [7:0] awlen,
    output logic [2:0] awsize,
    output logic       awvalid,
    input  logic       awready,
    output beat_t      wdata,
    output strb_t      wstrb,
    output logic       wlast,
    output logic       wvalid,
    input  logic       wready,
    input  logic [1:0] bresp,
    input  logic       bvalid,
    output logic       bready,
    output logic       busy,
    output logic       dma_done,
    output logic       dma_error
);

    localparam int OUT_W = $clog2(`DMA_MAX_OUTSTANDING + 1);
    localparam int BEAT_BYTES = `DMA_BEAT_W / 8;

    wr_state_t state;
    addr_t next_addr;
    logic [OUT_W-1:0] outstanding;
    logic aw_done;
    logic w_done;
    logic issue_ok;
    logic aw_fire;
    logic w_fire;
    logic b_fire;
    logic pop;

    // Once raised the gate stays open, as pending responses can only retire
    assign issue_ok = (state == WR_RUN) && fb_valid &&
                      (outstanding < OUT_W'(`DMA_MAX_OUTSTANDING));

    assign awvalid = issue_ok && !aw_done;
    assign wvalid = issue_ok && !w_done;
    assign aw_fire = awvalid && awready;
    assign w_fire = wvalid && wready;
    assign b_fire = bvalid && bready;

    // The head entry leaves once both channels have taken it
    assign pop = (aw_done || aw_fire) && (w_done || w_fire);
    assign fb_ready = pop;

    assign awaddr = next_addr;
    assign awlen = 8'd0;
    assign awsize = 3'($clog2(BEAT_BYTES));
    assign wdata = fb_beat;
    assign wstrb = fb_strb;
    assign wlast = 1'b1;
    assign bready = 1'b1;
    assign busy = (state != WR_IDLE);

    always_ff @(posedge axi_out or negedge rst_n) begin
        if (!rst_n) begin
            state <= WR_IDLE;
            next_addr <= '0;
            outstanding <= '0;
            aw_done <= 1'b0;
            w_done <= 1'b0;
            dma_done <= 1'b0;
            dma_error <= 1'b0;
        end else begin
            dma_done <= 1'b0;

            if (pop && !b_fire) begin
                outstanding <= outstanding + 1'b1;
            end else if (b_fire && !pop) begin
                outstanding <= outstanding - 1'b1;
            end

            if (b_fire && bresp != 2'b00) begin
                dma_error <= 1'b1;
            end

            if (pop) begin
                aw_done <= 1'b0;
                w_done <= 1'b0;
                next_addr <= next_addr + addr_t'(BEAT_BYTES);
            end else begin
                aw_done <= aw_done || aw_fire;
                w_done <= w_done || w_fire;
            end

            case (state)
                WR_IDLE: begin
                    if (start) begin
                        state <= WR_RUN;
                        next_addr <= base_addr;
                        dma_error <= 1'b0;
                    end
                end
                WR_RUN: begin
                    if (pop && fb_last) begin
                        state <= WR_DRAIN;
                    end
                end
                WR_DRAIN: begin
                    // Last pending response retires, report completion next cycle
                    if (b_fire && outstanding == OUT_W'(1)) begin
                        state <= WR_IDLE;
                        dma_done <= 1'b1;
                    end
                end
                default: begin
                    state <= WR_IDLE;
                end
            endcase
        end
    end

endmodule

//--- design/beat_fifo.sv
// Circular buffer of beats with their strobe and end of frame flag
`timescale 1ns/1ps

module beat_fifo
    import dma_pkg::*;
#(
    parameter int DEPTH = 8
) (
    input  logic  axi_out,
    input  logic  rst_n,
    input  beat_t pk_beat,
    input  strb_t pk_strb,
    input  logic  pk_last,
    input  logic  pk_valid,
    output logic  pk_ready,
    output beat_t fb_beat,
    output strb_t fb_strb,
    output logic  fb_last,
    output logic  fb_valid,
    input  logic  fb_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    beat_t mem_beat [DEPTH];
    strb_t mem_strb [DEPTH];
    logic mem_last [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0] count;
    logic push;
    logic pop;

    assign pk_ready = (count != (PTR_W + 1)'(DEPTH));
    assign fb_valid = (count != '0);
    assign push = pk_valid && pk_ready;
    assign pop = fb_valid && fb_ready;

    // Head entry is presented straight from storage
    assign fb_beat = mem_beat[rd_ptr];
    assign fb_strb = mem_strb[rd_ptr];
    assign fb_last = mem_last[rd_ptr];

    always_ff @(posedge axi_out or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge axi_out) begin
        if (push) begin
            mem_beat[wr_ptr] <= pk_beat;
            mem_strb[wr_ptr] <= pk_strb;
            mem_last[wr_ptr] <= pk_last;
        end
    end

endmodule

//--- design/sample_packer.sv
// Packs tagged stream samples two per beat and closes the frame on count or last
`timescale 1ns/1ps
`include "dma_cfg.svh"

module sample_packer
    import dma_pkg::*;
(
    input  logic    axi_out,
    input  logic    rst_n,
    input  logic    start,
    input  count_t  sample_count,
    input  sample_t in_data,
    input  tag_t    in_tag,
    input  logic    in_last,
    input  logic    in_valid,
    output logic    in_ready,
    output beat_t   pk_beat,
    output strb_t   pk_strb,
    output logic    pk_last,
    output logic    pk_valid,
    input  logic    pk_ready
);

    localparam int REC_W = `DMA_BEAT_W / 2;
    localparam int HALF_STRB = `DMA_STRB_W / 2;

    pack_state_t state;
    count_t remaining;
    logic [REC_W-1:0] lower_rec;
    logic [REC_W-1:0] record;
    logic accept;
    logic closing;

    // Samples are taken only when the output register is empty or emptying
    assign in_ready = (state != PK_IDLE) && (!pk_valid || pk_ready);
    assign accept = in_valid && in_ready;
    assign closing = (remaining == count_t'(1)) || in_last;

    // Tag is zero extended into the upper word of the record
    assign record = {{(REC_W - `DMA_DATA_W - `DMA_TAG_W){1'b0}}, in_tag, in_data};

    always_ff @(posedge axi_out or negedge rst_n) begin
        if (!rst_n) begin
            state <= PK_IDLE;
            remaining <= '0;
            pk_valid <= 1'b0;
        end else begin
            if (pk_valid && pk_ready) begin
                pk_valid <= 1'b0;
            end
            if (start) begin
                state <= PK_LOWER;
                remaining <= sample_count;
            end else if (accept) begin
                remaining <= remaining - count_t'(1);
                if (state == PK_UPPER || closing) begin
                    pk_valid <= 1'b1;
                end
                if (closing) begin
                    state <= PK_IDLE;
                end else if (state == PK_LOWER) begin
                    state <= PK_UPPER;
                end else begin
                    state <= PK_LOWER;
                end
            end
        end
    end

    always_ff @(posedge axi_out) begin
        if (accept) begin
            if (state == PK_LOWER) begin
                lower_rec <= record;
            end
            if (state == PK_UPPER) begin
                pk_beat <= {record, lower_rec};
                pk_strb <= '1;
                pk_last <= closing;
            end else if (closing) begin
                // Frame ended on a lower half, upper record stays empty
                pk_beat <= {{REC_W{1'b0}}, record};
                pk_strb <= {{HALF_STRB{1'b0}}, {HALF_STRB{1'b1}}};
                pk_last <= 1'b1;
            end
        end
    end

endmodule

//--- design/dma_regs.sv
// Register write port holding the transfer setup and issuing the start pulse
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_regs
    import dma_pkg::*;
(
    input  logic                       axi_out,
    input  logic                       rst_n,
    input  logic [`DMA_REG_ADDR_W-1:0] reg_addr,
    input  logic [`DMA_REG_DATA_W-1:0] reg_wdata,
    input  logic                       reg_valid,
    output logic                       reg_ready,
    input  logic                       busy,
    output addr_t                      base_addr,
    output count_t                     sample_count,
    output logic                       start
);

    logic wr_fire;

    // The start cycle itself also blocks writes, busy follows one cycle later
    assign reg_ready = !busy && !start;
    assign wr_fire = reg_valid && reg_ready;

    always_ff @(posedge axi_out or negedge rst_n) begin
        if (!rst_n) begin
            base_addr <= '0;
            sample_count <= '0;
            start <= 1'b0;
        end else begin
            start <= 1'b0;
            if (wr_fire) begin
                case (reg_addr)
                    `DMA_REG_BASE_LO: begin
                        base_addr[31:0] <= reg_wdata;
                    end
                    `DMA_REG_BASE_HI: begin
                        // Only the bits above 32 that the address bus carries
                        base_addr[`DMA_ADDR_W-1:32] <= reg_wdata[`DMA_ADDR_W-33:0];
                    end
                    `DMA_REG_COUNT: begin
                        sample_count <= reg_wdata;
                    end
                    `DMA_REG_CTRL: begin
                        start <= reg_wdata[0];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

//--- design/dma_pkg.sv
// Shared vector types and FSM encodings of the write DMA
`include "dma_cfg.svh"

package dma_pkg;

    typedef logic [`DMA_DATA_W-1:0] sample_t;
    typedef logic [`DMA_TAG_W-1:0] tag_t;

    // Upper tag, upper data, lower tag, lower data from the top bit down
    typedef logic [`DMA_BEAT_W-1:0] beat_t;
    typedef logic [`DMA_STRB_W-1:0] strb_t;

    typedef logic [`DMA_ADDR_W-1:0] addr_t;
    typedef logic [`DMA_COUNT_W-1:0] count_t;

    // Which half of the beat the next sample fills
    typedef enum logic [1:0] {
        PK_IDLE,
        PK_LOWER,
        PK_UPPER
    } pack_state_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_RUN,
        WR_DRAIN
    } wr_state_t;

endpackage

//--- include/dma_cfg.svh
// Size and register map constants for the stream-to-memory write DMA
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// Stream sample and destination tag
`define DMA_DATA_W 32
`define DMA_TAG_W 12

// Memory side, one beat holds two packed records
`define DMA_BEAT_W 128
`define DMA_STRB_W (`DMA_BEAT_W / 8)
`define DMA_ADDR_W 49

// Transfer length counter
`define DMA_COUNT_W 32

// Buffering and write issue limits
`define DMA_FIFO_DEPTH 8
`define DMA_MAX_OUTSTANDING 4

// Register write port
`define DMA_REG_ADDR_W 4
`define DMA_REG_DATA_W 32
`define DMA_REG_BASE_LO 4'h0
`define DMA_REG_BASE_HI 4'h4
`define DMA_REG_COUNT 4'h8
`define DMA_REG_CTRL 4'hC

`endif
